// File: src/lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Datapath widths
`define LSU_XLEN      32
`define LSU_OFFSET_W  12

// ************************************************************
// Memory map
// ************************************************************

// Data closely coupled memory, 64 KB window
`define LSU_DCCM_BASE 32'hF004_0000
`define LSU_DCCM_SIZE 32'h0001_0000

// Interrupt controller registers, 32 KB window
`define LSU_PIC_BASE  32'hF00C_0000
`define LSU_PIC_SIZE  32'h0000_8000

// Anything outside both windows is an external bus access
// Both sizes must stay powers of two for the mask decode

`endif // LSU_CONFIG_SVH

// File: src/lsu_pkg.sv
`include "lsu_config.svh"

package lsu_pkg;

   // ************************************************************
   // Control packet
   // ************************************************************

   // Valid is the lowest bit so the rest slices off as one field
   // Only one of by, half, word and dword is set
   typedef struct packed {
      logic by;
      logic half;
      logic word;
      logic dword;
      logic load;
      logic store;
      logic unsign;
      logic dma;
      logic valid;
   } lsu_pkt_t;

   // ************************************************************
   // Stage payloads
   // ************************************************************

   // Carried through DC2 and DC3
   typedef struct packed {
      logic [$bits(lsu_pkt_t)-2:0] ctl;
      logic [`LSU_XLEN-1:0]        start_addr;
      logic [`LSU_XLEN-1:0]        end_addr;
      logic [`LSU_XLEN-1:0]        store_data;
      logic                        in_dccm;
      logic                        in_pic;
      logic                        external;
      logic                        access_fault;
      logic                        misaligned_fault;
   } lsu_early_t;

   // Carried through DC4 and DC5, faults are resolved by then
   typedef struct packed {
      logic [$bits(lsu_pkt_t)-2:0] ctl;
      logic [`LSU_XLEN-1:0]        start_addr;
      logic [`LSU_XLEN-1:0]        store_data;
      logic                        external;
   } lsu_late_t;

endpackage

// File: src/lsu_addr_gen.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_addr_gen
   import lsu_pkg::*;
(
   input  logic                     clk,
   input  logic                     reset,
   input  lsu_pkt_t                 lsu_p,
   input  logic [`LSU_XLEN-1:0]     exu_lsu_rs1_d,
   input  logic [`LSU_XLEN-1:0]     exu_lsu_rs2_d,
   input  logic [`LSU_OFFSET_W-1:0] dec_lsu_offset_d,
   input  logic                     dma_dccm_req,
   input  logic [`LSU_XLEN-1:0]     dma_mem_addr,
   input  logic [2:0]               dma_mem_sz,
   input  logic                     dma_mem_write,
   input  logic [63:0]              dma_mem_wdata,
   input  logic                     flush_dc2_up,
   output lsu_pkt_t                 lsu_pkt_dc1,
   output logic [`LSU_XLEN-1:0]     lsu_addr_dc1,
   output logic [`LSU_XLEN-1:0]     end_addr_dc1,
   output logic [`LSU_XLEN-1:0]     store_data_dc1
);

   lsu_pkt_t                 dma_pkt_d;
   lsu_pkt_t                 pkt_d;
   logic [`LSU_XLEN-1:0]     base_d;
   logic [`LSU_OFFSET_W-1:0] offset_d;
   logic [63:0]              dma_wdata_lane;
   logic [`LSU_XLEN-1:0]     store_data_d;
   logic [`LSU_XLEN-1:0]     base_dc1;
   logic [`LSU_OFFSET_W-1:0] offset_dc1;
   logic [2:0]               size_extra_dc1;

   // DMA wins the slot and uses its address as is
   assign base_d   = dma_dccm_req ? dma_mem_addr : exu_lsu_rs1_d;
   assign offset_d = dma_dccm_req ? '0 : dec_lsu_offset_d;

   always_comb begin
      dma_pkt_d       = '0;
      dma_pkt_d.valid = dma_dccm_req;
      dma_pkt_d.dma   = 1'b1;
      dma_pkt_d.store = dma_mem_write;
      dma_pkt_d.load  = ~dma_mem_write;
      dma_pkt_d.by    = (dma_mem_sz == 3'd0);
      dma_pkt_d.half  = (dma_mem_sz == 3'd1);
      dma_pkt_d.word  = (dma_mem_sz == 3'd2);
      dma_pkt_d.dword = (dma_mem_sz == 3'd3);
   end

   always_comb begin
      pkt_d       = dma_dccm_req ? dma_pkt_d : lsu_p;
      pkt_d.valid = (lsu_p.valid & ~flush_dc2_up) | dma_dccm_req;
   end

   // Move the addressed byte lane down to bit 0, like a core store
   assign dma_wdata_lane = dma_mem_wdata >> {dma_mem_addr[2:0], 3'b000};
   assign store_data_d   = dma_dccm_req ? dma_wdata_lane[`LSU_XLEN-1:0] : exu_lsu_rs2_d;

   // ************************************************************
   // DC1 registers
   // ************************************************************

   always_ff @(posedge clk) begin
      if (reset) begin
         lsu_pkt_dc1 <= '0;
      end else begin
         lsu_pkt_dc1 <= pkt_d;
      end
   end

   always_ff @(posedge clk) begin
      if (pkt_d.valid) begin
         base_dc1       <= base_d;
         offset_dc1     <= offset_d;
         store_data_dc1 <= store_data_d;
      end
   end

   assign lsu_addr_dc1 = base_dc1 +
      {{(`LSU_XLEN-`LSU_OFFSET_W){offset_dc1[`LSU_OFFSET_W-1]}}, offset_dc1};

   // Last byte touched
   always_comb begin
      size_extra_dc1 = 3'd0;
      if (lsu_pkt_dc1.half) begin
         size_extra_dc1 = 3'd1;
      end else if (lsu_pkt_dc1.word) begin
         size_extra_dc1 = 3'd3;
      end else if (lsu_pkt_dc1.dword) begin
         size_extra_dc1 = 3'd7;
      end
   end

   assign end_addr_dc1 = lsu_addr_dc1 + {{(`LSU_XLEN-3){1'b0}}, size_extra_dc1};

endmodule

// File: src/lsu_addr_check.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_addr_check
   import lsu_pkg::*;
(
   input  lsu_pkt_t             lsu_pkt_dc1,
   input  logic [`LSU_XLEN-1:0] start_addr_dc1,
   input  logic [`LSU_XLEN-1:0] end_addr_dc1,
   output logic                 addr_in_dccm_dc1,
   output logic                 addr_in_pic_dc1,
   output logic                 addr_external_dc1,
   output logic                 access_fault_dc1,
   output logic                 misaligned_fault_dc1
);

   localparam logic [`LSU_XLEN-1:0] dccm_mask = ~(`LSU_DCCM_SIZE - 1);
   localparam logic [`LSU_XLEN-1:0] pic_mask  = ~(`LSU_PIC_SIZE - 1);

   logic end_in_dccm;
   logic end_in_pic;
   logic region_cross;
   logic pic_bad_size;
   logic unaligned;
   logic fault_qual;

   // ************************************************************
   // Region decode
   // ************************************************************

   assign addr_in_dccm_dc1  = (start_addr_dc1 & dccm_mask) == `LSU_DCCM_BASE;
   assign addr_in_pic_dc1   = (start_addr_dc1 & pic_mask) == `LSU_PIC_BASE;
   assign addr_external_dc1 = ~addr_in_dccm_dc1 & ~addr_in_pic_dc1;

   assign end_in_dccm = (end_addr_dc1 & dccm_mask) == `LSU_DCCM_BASE;
   assign end_in_pic  = (end_addr_dc1 & pic_mask) == `LSU_PIC_BASE;

   // ************************************************************
   // Faults
   // ************************************************************

   // Access spills out of the region it started in
   assign region_cross = (addr_in_dccm_dc1 != end_in_dccm) | (addr_in_pic_dc1 != end_in_pic);

   // PIC registers only take full words
   assign pic_bad_size = addr_in_pic_dc1 & ~lsu_pkt_dc1.word;

   assign unaligned = (lsu_pkt_dc1.half  & start_addr_dc1[0]) |
                      (lsu_pkt_dc1.word  & (|start_addr_dc1[1:0])) |
                      (lsu_pkt_dc1.dword & (|start_addr_dc1[2:0]));

   // DMA requests never raise a core fault
   assign fault_qual = lsu_pkt_dc1.valid & ~lsu_pkt_dc1.dma;

   assign access_fault_dc1     = fault_qual & (region_cross | pic_bad_size);
   assign misaligned_fault_dc1 = fault_qual & addr_external_dc1 & unaligned;

endmodule

// File: src/lsu_pipe_stage.sv
`timescale 1ns/1ps

module lsu_pipe_stage #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     valid_in,
   input  logic     flush,
   input  logic     flush_exempt,
   input  payload_t payload_in,
   output logic     valid_out,
   output payload_t payload_out
);

   logic kill;

   // Flush drops the entry unless it is exempt
   assign kill = flush & ~flush_exempt;

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_out <= 1'b0;
      end else begin
         valid_out <= valid_in & ~kill;
      end
   end

   // Payload holds still while bubbles pass
   always_ff @(posedge clk) begin
      if (valid_in) begin
         payload_out <= payload_in;
      end
   end

endmodule

// File: src/lsu_load_format.sv
`timescale 1ns/1ps

module lsu_load_format
   import lsu_pkg::*;
(
   input  lsu_pkt_t    pkt_dc3,
   input  logic        external_dc3,
   input  logic [31:0] lsu_ld_data_dc3,
   input  logic [31:0] bus_read_data_dc3,
   output logic [31:0] lsu_result_dc3
);

   logic [31:0] ld_data;
   logic        sign_ext;

   // Bus data for external space, local memory otherwise
   assign ld_data = external_dc3 ? bus_read_data_dc3 : lsu_ld_data_dc3;

   assign sign_ext = ~pkt_dc3.unsign;

   // ************************************************************
   // Size extract and extension
   // ************************************************************

   always_comb begin
      lsu_result_dc3 = '0;
      if (pkt_dc3.by) begin
         lsu_result_dc3 = {{24{sign_ext & ld_data[7]}}, ld_data[7:0]};
      end else if (pkt_dc3.half) begin
         lsu_result_dc3 = {{16{sign_ext & ld_data[15]}}, ld_data[15:0]};
      end else if (pkt_dc3.word) begin
         lsu_result_dc3 = ld_data;
      end
      // no size bit leaves zero
   end

endmodule

// File: src/lsu_lsc_ctl.sv
`timescale 1ns/1ps

module lsu_lsc_ctl
   import lsu_pkg::*;
(
   input  logic        clk,
   input  logic        reset,

   // Decode request
   input  lsu_pkt_t    lsu_p,
   input  logic [31:0] exu_lsu_rs1_d,
   input  logic [31:0] exu_lsu_rs2_d,
   input  logic [11:0] dec_lsu_offset_d,

   // DMA master
   input  logic        dma_dccm_req,
   input  logic [31:0] dma_mem_addr,
   input  logic [2:0]  dma_mem_sz,
   input  logic        dma_mem_write,
   input  logic [63:0] dma_mem_wdata,

   // Flushes
   input  logic        flush_dc2_up,
   input  logic        flush_dc3,
   input  logic        flush_dc4,
   input  logic        flush_dc5,

   // Load data, read in DC3
   input  logic [31:0] lsu_ld_data_dc3,
   input  logic [31:0] bus_read_data_dc3,

   output logic [31:0] lsu_addr_dc1,
   output logic [31:0] end_addr_dc1,
   output logic        lsu_exc_dc2,
   output logic [31:0] lsu_addr_dc3,
   output logic        addr_in_dccm_dc3,
   output logic        addr_in_pic_dc3,
   output logic        addr_external_dc3,
   output logic [31:0] lsu_result_dc3,
   output logic        lsu_exc_valid_dc3,
   output logic        lsu_exc_type_dc3,
   output logic        lsu_exc_store_dc3,
   output logic [31:0] lsu_exc_addr_dc3,
   output logic        lsu_commit_dc5,
   output logic [31:0] lsu_addr_dc5,
   output logic [31:0] store_data_dc5
);

   localparam int ctl_w = $bits(lsu_pkt_t) - 1;

   lsu_pkt_t    lsu_pkt_dc1;
   lsu_pkt_t    lsu_pkt_dc2;
   lsu_pkt_t    lsu_pkt_dc3;
   lsu_pkt_t    lsu_pkt_dc4;
   lsu_pkt_t    lsu_pkt_dc5;
   logic [31:0] store_data_dc1;
   logic        in_dccm_dc1;
   logic        in_pic_dc1;
   logic        external_dc1;
   logic        access_fault_dc1;
   logic        misaligned_fault_dc1;
   logic        valid_dc2;
   logic        valid_dc3;
   logic        valid_dc4;
   logic        valid_dc5;
   lsu_early_t  early_dc1;
   lsu_early_t  early_dc2;
   lsu_early_t  early_dc3;
   lsu_late_t   late_dc3;
   lsu_late_t   late_dc4;
   lsu_late_t   late_dc5;

   // ************************************************************
   // DC1 address generation and memory map check
   // ************************************************************

   lsu_addr_gen u_addr_gen (
      .clk              (clk),
      .reset            (reset),
      .lsu_p            (lsu_p),
      .exu_lsu_rs1_d    (exu_lsu_rs1_d),
      .exu_lsu_rs2_d    (exu_lsu_rs2_d),
      .dec_lsu_offset_d (dec_lsu_offset_d),
      .dma_dccm_req     (dma_dccm_req),
      .dma_mem_addr     (dma_mem_addr),
      .dma_mem_sz       (dma_mem_sz),
      .dma_mem_write    (dma_mem_write),
      .dma_mem_wdata    (dma_mem_wdata),
      .flush_dc2_up     (flush_dc2_up),
      .lsu_pkt_dc1      (lsu_pkt_dc1),
      .lsu_addr_dc1     (lsu_addr_dc1),
      .end_addr_dc1     (end_addr_dc1),
      .store_data_dc1   (store_data_dc1)
   );

   lsu_addr_check u_addr_check (
      .lsu_pkt_dc1          (lsu_pkt_dc1),
      .start_addr_dc1       (lsu_addr_dc1),
      .end_addr_dc1         (end_addr_dc1),
      .addr_in_dccm_dc1     (in_dccm_dc1),
      .addr_in_pic_dc1      (in_pic_dc1),
      .addr_external_dc1    (external_dc1),
      .access_fault_dc1     (access_fault_dc1),
      .misaligned_fault_dc1 (misaligned_fault_dc1)
   );

   assign early_dc1 = '{ctl:              lsu_pkt_dc1[ctl_w:1],
                        start_addr:       lsu_addr_dc1,
                        end_addr:         end_addr_dc1,
                        store_data:       store_data_dc1,
                        in_dccm:          in_dccm_dc1,
                        in_pic:           in_pic_dc1,
                        external:         external_dc1,
                        access_fault:     access_fault_dc1,
                        misaligned_fault: misaligned_fault_dc1};

   // ************************************************************
   // Stage chain
   // ************************************************************

   lsu_pipe_stage #(.payload_t(lsu_early_t)) u_dc2 (
      .clk          (clk),
      .reset        (reset),
      .valid_in     (lsu_pkt_dc1.valid),
      .flush        (flush_dc2_up),
      .flush_exempt (lsu_pkt_dc1.dma),
      .payload_in   (early_dc1),
      .valid_out    (valid_dc2),
      .payload_out  (early_dc2)
   );

   assign lsu_pkt_dc2 = {early_dc2.ctl, valid_dc2};

   lsu_pipe_stage #(.payload_t(lsu_early_t)) u_dc3 (
      .clk          (clk),
      .reset        (reset),
      .valid_in     (valid_dc2),
      .flush        (flush_dc2_up),
      .flush_exempt (lsu_pkt_dc2.dma),
      .payload_in   (early_dc2),
      .valid_out    (valid_dc3),
      .payload_out  (early_dc3)
   );

   assign lsu_pkt_dc3 = {early_dc3.ctl, valid_dc3};

   assign late_dc3 = '{ctl:        early_dc3.ctl,
                       start_addr: early_dc3.start_addr,
                       store_data: early_dc3.store_data,
                       external:   early_dc3.external};

   lsu_pipe_stage #(.payload_t(lsu_late_t)) u_dc4 (
      .clk          (clk),
      .reset        (reset),
      .valid_in     (valid_dc3),
      .flush        (flush_dc3),
      .flush_exempt (lsu_pkt_dc3.dma),
      .payload_in   (late_dc3),
      .valid_out    (valid_dc4),
      .payload_out  (late_dc4)
   );

   assign lsu_pkt_dc4 = {late_dc4.ctl, valid_dc4};

   lsu_pipe_stage #(.payload_t(lsu_late_t)) u_dc5 (
      .clk          (clk),
      .reset        (reset),
      .valid_in     (valid_dc4),
      .flush        (flush_dc4),
      .flush_exempt (lsu_pkt_dc4.dma),
      .payload_in   (late_dc4),
      .valid_out    (valid_dc5),
      .payload_out  (late_dc5)
   );

   assign lsu_pkt_dc5 = {late_dc5.ctl, valid_dc5};

   // ************************************************************
   // DC3 load result and exception report
   // ************************************************************

   lsu_load_format u_load_format (
      .pkt_dc3           (lsu_pkt_dc3),
      .external_dc3      (early_dc3.external),
      .lsu_ld_data_dc3   (lsu_ld_data_dc3),
      .bus_read_data_dc3 (bus_read_data_dc3),
      .lsu_result_dc3    (lsu_result_dc3)
   );

   assign lsu_addr_dc3      = early_dc3.start_addr;
   assign addr_in_dccm_dc3  = early_dc3.in_dccm;
   assign addr_in_pic_dc3   = early_dc3.in_pic;
   assign addr_external_dc3 = early_dc3.external;

   // Early warning one stage ahead of the precise report
   assign lsu_exc_dc2 = valid_dc2 & (early_dc2.access_fault | early_dc2.misaligned_fault);

   assign lsu_exc_valid_dc3 = valid_dc3 & ~lsu_pkt_dc3.dma & ~flush_dc3 &
                              (early_dc3.access_fault | early_dc3.misaligned_fault);
   // High means access fault
   assign lsu_exc_type_dc3  = early_dc3.access_fault;
   assign lsu_exc_store_dc3 = lsu_pkt_dc3.store;
   assign lsu_exc_addr_dc3  = early_dc3.start_addr;

   // ************************************************************
   // DC5 commit
   // ************************************************************

   assign lsu_commit_dc5 = valid_dc5 & (lsu_pkt_dc5.load | lsu_pkt_dc5.store) &
                           ~lsu_pkt_dc5.dma & ~flush_dc5;
   assign lsu_addr_dc5   = late_dc5.start_addr;
   assign store_data_dc5 = late_dc5.store_data;

endmodule

// File: tests/lsu_lsc_ctl_chk.sv
`timescale 1ns/1ps

module lsu_lsc_ctl_chk (
   input logic clk,
   input logic reset,
   input logic valid_dc3,
   input logic dma_dc3,
   input logic addr_in_dccm_dc3,
   input logic addr_in_pic_dc3,
   input logic addr_external_dc3,
   input logic lsu_exc_dc2,
   input logic lsu_exc_valid_dc3,
   input logic lsu_commit_dc5,
   input logic flush_dc2_up,
   input logic flush_dc3
);

   logic [2:0] cycles_since_reset;

   // Saturating count of clock edges since reset was released
   always_ff @(posedge clk) begin
      if (reset) begin
         cycles_since_reset <= '0;
      end else if (cycles_since_reset != 3'd7) begin
         cycles_since_reset <= cycles_since_reset + 3'd1;
      end
   end

   // ************************************************************
   // Properties
   // ************************************************************

   region_onehot: assert property (@(posedge clk) disable iff (reset)
      valid_dc3 |-> $onehot0({addr_in_dccm_dc3, addr_in_pic_dc3, addr_external_dc3}))
      else $error("More than one region flag set in DC3");

   quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
      (cycles_since_reset < 3'd5) |-> !lsu_commit_dc5)
      else $error("Commit within five cycles of reset");

   no_dma_exception: assert property (@(posedge clk) disable iff (reset)
      lsu_exc_valid_dc3 |-> !dma_dc3)
      else $error("Exception reported for a DMA packet in DC3");

   // Early exception must turn into the precise one unless flushed
   exc_follows: assert property (@(posedge clk) disable iff (reset)
      (lsu_exc_dc2 && !flush_dc2_up) |=> (lsu_exc_valid_dc3 || flush_dc3))
      else $error("DC2 exception not followed by DC3 exception");

endmodule

bind lsu_lsc_ctl lsu_lsc_ctl_chk lsu_lsc_ctl_chk_inst (
   .clk               (clk),
   .reset             (reset),
   .valid_dc3         (valid_dc3),
   .dma_dc3           (lsu_pkt_dc3.dma),
   .addr_in_dccm_dc3  (addr_in_dccm_dc3),
   .addr_in_pic_dc3   (addr_in_pic_dc3),
   .addr_external_dc3 (addr_external_dc3),
   .lsu_exc_dc2       (lsu_exc_dc2),
   .lsu_exc_valid_dc3 (lsu_exc_valid_dc3),
   .lsu_commit_dc5    (lsu_commit_dc5),
   .flush_dc2_up      (flush_dc2_up),
   .flush_dc3         (flush_dc3)
);

// File: tests/lsu_lsc_ctl_tb.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_lsc_ctl_tb
   import lsu_pkg::*;
();

   logic        clk = 1'b0;
   logic        reset;
   lsu_pkt_t    lsu_p;
   logic [31:0] exu_lsu_rs1_d;
   logic [31:0] exu_lsu_rs2_d;
   logic [11:0] dec_lsu_offset_d;
   logic        dma_dccm_req;
   logic [31:0] dma_mem_addr;
   logic [2:0]  dma_mem_sz;
   logic        dma_mem_write;
   logic [63:0] dma_mem_wdata;
   logic        flush_dc2_up;
   logic        flush_dc3;
   logic        flush_dc4;
   logic        flush_dc5;
   logic [31:0] lsu_ld_data_dc3;
   logic [31:0] bus_read_data_dc3;
   logic [31:0] lsu_addr_dc1;
   logic [31:0] end_addr_dc1;
   logic        lsu_exc_dc2;
   logic [31:0] lsu_addr_dc3;
   logic        addr_in_dccm_dc3;
   logic        addr_in_pic_dc3;
   logic        addr_external_dc3;
   logic [31:0] lsu_result_dc3;
   logic        lsu_exc_valid_dc3;
   logic        lsu_exc_type_dc3;
   logic        lsu_exc_store_dc3;
   logic [31:0] lsu_exc_addr_dc3;
   logic        lsu_commit_dc5;
   logic [31:0] lsu_addr_dc5;
   logic [31:0] store_data_dc5;
   int          mismatch_count = 0;
   int          failure_count = 0;

   always #10 clk = ~clk;

   lsu_lsc_ctl lsu_lsc_ctl_inst (.*);

   // ************************************************************
   // Helpers
   // ************************************************************

   task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
      assert (got === exp) else begin
         $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
         mismatch_count++;
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      assert (got === exp) else begin
         $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
         mismatch_count++;
      end
   endtask

   // Size 0, 1, 2 for byte, half, word
   function automatic lsu_pkt_t make_pkt(input logic [1:0] size, input logic is_store,
                                         input logic uns);
      lsu_pkt_t p;
      p        = '0;
      p.valid  = 1'b1;
      p.load   = ~is_store;
      p.store  = is_store;
      p.unsign = uns;
      p.by     = (size == 2'd0);
      p.half   = (size == 2'd1);
      p.word   = (size == 2'd2);
      return p;
   endfunction

   function automatic logic [31:0] extend_load(input logic [31:0] data, input logic [1:0] size,
                                               input logic uns);
      logic [31:0] res;
      case (size)
         2'd0:    res = uns ? {24'h0, data[7:0]} : {{24{data[7]}}, data[7:0]};
         2'd1:    res = uns ? {16'h0, data[15:0]} : {{16{data[15]}}, data[15:0]};
         default: res = data;
      endcase
      return res;
   endfunction

   task automatic idle_inputs();
      lsu_p             = '0;
      exu_lsu_rs1_d     = '0;
      exu_lsu_rs2_d     = '0;
      dec_lsu_offset_d  = '0;
      dma_dccm_req      = 1'b0;
      dma_mem_addr      = '0;
      dma_mem_sz        = '0;
      dma_mem_write     = 1'b0;
      dma_mem_wdata     = '0;
      flush_dc2_up      = 1'b0;
      flush_dc3         = 1'b0;
      flush_dc4         = 1'b0;
      flush_dc5         = 1'b0;
      lsu_ld_data_dc3   = '0;
      bus_read_data_dc3 = '0;
   endtask

   // Idle cycles, inputs cleared on each falling edge
   task automatic skip_cycles(input int n);
      for (int i = 0; i < n; i++) begin
         @(negedge clk);
         idle_inputs();
      end
   endtask

   // Decode request in the D stage, sampled at the next rising edge
   task automatic issue_core(input lsu_pkt_t pkt, input logic [31:0] rs1,
                             input logic [31:0] rs2, input logic [11:0] off);
      @(negedge clk);
      idle_inputs();
      lsu_p            = pkt;
      exu_lsu_rs1_d    = rs1;
      exu_lsu_rs2_d    = rs2;
      dec_lsu_offset_d = off;
   endtask

   task automatic wait_commit(input int limit, output int cycles, output logic seen);
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles < limit) begin
         @(negedge clk);
         idle_inputs();
         #5;
         cycles++;
         seen = lsu_commit_dc5;
      end
   endtask

   // ************************************************************
   // Tests
   // ************************************************************

   task automatic dccm_load_test();
      logic [31:0] base;
      logic [31:0] r;
      logic [31:0] ld_word;
      logic [31:0] exp_addr;
      logic [11:0] off;
      logic [1:0]  size;
      logic        uns;
      logic        seen;
      int          cycles;
      for (int n = 0; n < 12; n++) begin
         size    = 2'(n % 3);
         uns     = ((n / 3) % 2) == 1;
         r       = $urandom;
         base    = `LSU_DCCM_BASE + 32'h1000 + (r % 32'hE000);
         r       = $urandom;
         off     = r[11:0];
         ld_word = $urandom;
         // First signed and unsigned pass has the sign bits set
         if (n < 6) begin
            ld_word = ld_word | 32'h0000_8080;
         end
         issue_core(make_pkt(size, 1'b0, uns), base, 32'h0, off);
         skip_cycles(1);
         #5;
         exp_addr = base + {{20{off[11]}}, off};
         check_word(lsu_addr_dc1, exp_addr, "DC1 start address");
         check_word(end_addr_dc1, exp_addr + ((size == 2'd0) ? 32'd0 :
                    (size == 2'd1) ? 32'd1 : 32'd3), "DC1 end address");
         skip_cycles(2);
         lsu_ld_data_dc3   = ld_word;
         bus_read_data_dc3 = ~ld_word;
         #5;
         check_bit(addr_in_dccm_dc3, 1'b1, "DCCM region flag");
         check_word(lsu_result_dc3, extend_load(ld_word, size, uns), "DCCM load result");
         wait_commit(4, cycles, seen);
         assert (seen) else begin
            $display("Timed out at %0t waiting for the commit of a DCCM load", $time);
            failure_count++;
         end
         check_word(32'(cycles + 2), 32'd4, "cycles from DC1 to commit");
      end
   endtask

   task automatic external_load_test();
      logic [31:0] r;
      logic [31:0] base;
      logic [31:0] local_word;
      r          = $urandom;
      base       = {8'h20, r[23:2], 2'b00};
      local_word = $urandom;
      issue_core(make_pkt(2'd2, 1'b0, 1'b0), base, 32'h0, 12'h0);
      skip_cycles(3);
      lsu_ld_data_dc3   = local_word;
      bus_read_data_dc3 = ~local_word;
      #5;
      check_bit(addr_external_dc3, 1'b1, "external region flag");
      check_word(lsu_result_dc3, ~local_word, "external load result");
      skip_cycles(5);
   endtask

   task automatic run_fault(input lsu_pkt_t pkt, input logic [31:0] addr, input logic exp_type);
      issue_core(pkt, addr, 32'h0, 12'h0);
      skip_cycles(2);
      #5;
      check_bit(lsu_exc_dc2, 1'b1, "DC2 exception");
      skip_cycles(1);
      #5;
      check_bit(lsu_exc_valid_dc3, 1'b1, "DC3 exception valid");
      check_bit(lsu_exc_type_dc3, exp_type, "exception type");
      check_bit(lsu_exc_store_dc3, pkt.store, "exception store bit");
      check_word(lsu_exc_addr_dc3, addr, "exception address");
      skip_cycles(5);
   endtask

   task automatic fault_test();
      logic [31:0] r;
      r = $urandom;
      // Word that runs off the top of the DCCM
      run_fault(make_pkt(2'd2, 1'b0, 1'b0), `LSU_DCCM_BASE + `LSU_DCCM_SIZE - 32'd2, 1'b1);
      run_fault(make_pkt(2'd1, 1'b1, 1'b0), 32'h2000_0001 + {8'h0, r[23:4], 4'h0}, 1'b0);
   endtask

   task automatic flush_dc2_test();
      logic seen;
      int   cycles;
      issue_core(make_pkt(2'd2, 1'b0, 1'b0), `LSU_DCCM_BASE + `LSU_DCCM_SIZE - 32'd2, 32'h0,
                 12'h0);
      skip_cycles(1);
      flush_dc2_up = 1'b1;
      skip_cycles(1);
      #5;
      check_bit(lsu_exc_dc2, 1'b0, "DC2 exception after flush");
      skip_cycles(1);
      #5;
      check_bit(lsu_exc_valid_dc3, 1'b0, "DC3 exception after flush");
      wait_commit(3, cycles, seen);
      check_bit(seen, 1'b0, "commit of a flushed request");
   endtask

   task automatic flush_dc5_test();
      logic [31:0] r;
      r = $urandom;
      issue_core(make_pkt(2'd2, 1'b0, 1'b0), `LSU_DCCM_BASE + {16'h0, r[15:2], 2'b00}, 32'h0,
                 12'h0);
      skip_cycles(5);
      flush_dc5 = 1'b1;
      #5;
      check_bit(lsu_commit_dc5, 1'b0, "commit under flush_dc5");
      skip_cycles(1);
      #5;
      check_bit(lsu_commit_dc5, 1'b0, "commit after flush_dc5");
   endtask

   task automatic back_to_back_test();
      logic [31:0] addrs [0:3];
      logic [31:0] exp_q [$];
      logic [31:0] r;
      int          cyc;
      int          commits;
      for (int i = 0; i < 4; i++) begin
         r        = $urandom;
         addrs[i] = `LSU_DCCM_BASE + {16'h0, r[15:2], 2'b00};
      end
      cyc     = 0;
      commits = 0;
      while (commits < 4 && cyc < 12) begin
         @(negedge clk);
         idle_inputs();
         if (cyc < 4) begin
            // Alternate loads and stores
            lsu_p         = make_pkt(2'd2, cyc[0], 1'b0);
            exu_lsu_rs1_d = addrs[cyc[1:0]];
            exu_lsu_rs2_d = $urandom;
            exp_q.push_back(addrs[cyc[1:0]]);
         end
         #5;
         if (lsu_commit_dc5) begin
            if (exp_q.size() == 0) begin
               $display("Commit at %0t with no request left in flight", $time);
               failure_count++;
            end else begin
               check_word(lsu_addr_dc5, exp_q.pop_front(), "DC5 address in order");
               check_word(32'(cyc), 32'(commits + 5), "back to back commit cycle");
            end
            commits++;
         end
         cyc++;
      end
      assert (commits == 4) else begin
         $display("Timed out at %0t with %0d of 4 back to back commits", $time, commits);
         failure_count++;
      end
   endtask

   task automatic dma_write_test();
      logic [31:0] addr;
      logic [31:0] hi;
      logic [31:0] lo;
      // Lane 4 dword that would cross out of the DCCM for a core access
      addr = `LSU_DCCM_BASE + `LSU_DCCM_SIZE - 32'd4;
      hi   = $urandom;
      lo   = $urandom;
      @(negedge clk);
      idle_inputs();
      dma_dccm_req  = 1'b1;
      dma_mem_addr  = addr;
      dma_mem_sz    = 3'd3;
      dma_mem_write = 1'b1;
      dma_mem_wdata = {hi, lo};
      // Decode base and offset that the DMA request must override
      exu_lsu_rs1_d    = 32'h1234_5678;
      dec_lsu_offset_d = 12'h010;
      skip_cycles(1);
      #5;
      check_word(lsu_addr_dc1, addr, "DMA DC1 address");
      skip_cycles(1);
      #5;
      check_bit(lsu_exc_dc2, 1'b0, "DMA DC2 exception");
      skip_cycles(1);
      #5;
      check_bit(lsu_exc_valid_dc3, 1'b0, "DMA DC3 exception");
      skip_cycles(2);
      #5;
      check_bit(lsu_commit_dc5, 1'b0, "DMA commit");
      check_word(store_data_dc5, hi, "DMA DC5 store data");
      skip_cycles(2);
   endtask

   task automatic dma_flush_test();
      logic [31:0] r;
      logic [31:0] addr;
      r    = $urandom;
      addr = `LSU_PIC_BASE + {17'h0, r[14:2], 2'b00};
      @(negedge clk);
      idle_inputs();
      dma_dccm_req = 1'b1;
      dma_mem_addr = addr;
      dma_mem_sz   = 3'd2;
      flush_dc2_up = 1'b1;
      // Flush held through DC1 and DC2
      for (int i = 0; i < 2; i++) begin
         skip_cycles(1);
         flush_dc2_up = 1'b1;
      end
      skip_cycles(1);
      #5;
      check_word(lsu_addr_dc3, addr, "DMA DC3 address");
      check_bit(addr_in_pic_dc3, 1'b1, "DMA PIC region flag");
      check_bit(lsu_exc_valid_dc3, 1'b0, "DMA DC3 exception");
      skip_cycles(2);
      #5;
      check_word(lsu_addr_dc5, addr, "DMA DC5 address");
      check_bit(lsu_commit_dc5, 1'b0, "DMA commit");
      skip_cycles(2);
   endtask

   // ************************************************************
   // Main sequence
   // ************************************************************

   initial begin
      idle_inputs();
      reset = 1'b1;
      void'($urandom(9));
      for (int i = 0; i < 3; i++) begin
         @(posedge clk);
      end
      @(negedge clk);
      reset = 1'b0;

      dccm_load_test();
      external_load_test();
      fault_test();
      flush_dc2_test();
      flush_dc5_test();
      back_to_back_test();
      dma_write_test();
      dma_flush_test();

      $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
      if (mismatch_count == 0 && failure_count == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: sim.f
+incdir+src
src/lsu_pkg.sv
src/lsu_addr_gen.sv
src/lsu_addr_check.sv
src/lsu_pipe_stage.sv
src/lsu_load_format.sv
src/lsu_lsc_ctl.sv
tests/lsu_lsc_ctl_chk.sv
tests/lsu_lsc_ctl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f sim.f --top-module lsu_lsc_ctl_tb -o lsu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/lsu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Testbench failed" sim.log; then
   exit 1
fi
exit 0
